// ==== source/fix_params.svh ====
// FIX checksum checker protocol constants
// Byte values that frame a tag=value message and the limits used
// when the three-digit checksum trailer is decoded.

`ifndef FIX_PARAMS_SVH
`define FIX_PARAMS_SVH

// ---------------------------------------------------------------------------
// framing bytes
// ---------------------------------------------------------------------------
`define FIX_SOH        8'h01   // field delimiter
`define FIX_EQ         8'h3D   // "=" between tag and value

// checksum trailer tag is "10"
`define FIX_CHK_TAG0   8'h31
`define FIX_CHK_TAG1   8'h30

// ---------------------------------------------------------------------------
// trailer digits
// ---------------------------------------------------------------------------
`define FIX_DIGIT_LO   8'h30   // ascii "0"
`define FIX_DIGIT_HI   8'h39   // ascii "9"
`define FIX_CHK_DIGITS 2'd3    // digits expected after "10="

`endif

// ==== source/fix_stream_pkg.sv ====
// FIX checksum stream types
// Token kinds and the token records handed from one pipeline
// stage to the next inside the checksum checker.

package fix_stream_pkg;

	// byte class as seen by the field parser
	typedef enum logic [1:0] {
		TOK_BODY    = 2'd0, // summed message byte
		TOK_CHK_TAG = 2'd1, // "=" that completes "10=" at a field start
		TOK_DIGIT   = 2'd2, // trailer byte after the tag
		TOK_END     = 2'd3  // last byte of the message
	} tok_kind_t;

	// parser output
	typedef struct packed {
		logic       valid;
		tok_kind_t  kind;
		logic [7:0] data;
		logic       in_trailer; // checksum tag already seen
	} byte_tok_t;

	// accumulator output, computed rides along with the byte
	typedef struct packed {
		byte_tok_t  tok;
		logic [7:0] computed;
	} sum_tok_t;

	// decoder output
	typedef struct packed {
		sum_tok_t   stok;
		logic [9:0] value;     // up to 999
		logic [1:0] ndigits;   // saturates at 3
		logic       bad_digit;
	} dec_tok_t;

endpackage

// ==== source/fix_result_pkg.sv ====
// FIX checksum result types
// Per-message verdict as seen at the checker output.

package fix_result_pkg;

	// modulo-256 checksum value
	typedef logic [7:0] chk_sum_t;

	// one result per message
	typedef struct packed {
		chk_sum_t computed;   // sum over the message body
		chk_sum_t received;   // low bits of the decoded trailer
		logic     match;      // well formed and equal
		logic     format_err; // trailer missing or malformed
	} chk_result_t;

endpackage

// ==== source/fix_field_parser.sv ====
// FIX field parser
// First pipeline stage. Frames messages with sop/eop, tracks field
// starts and finds the "10=" checksum tag. Each accepted byte leaves
// one cycle later as a classified token.

`timescale 1ns/10ps
`include "fix_params.svh"

module fix_field_parser (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      byte_valid_i,
	input  logic                      sop_i,
	input  logic                      eop_i,
	input  logic [7:0]                data_i,
	output fix_stream_pkg::byte_tok_t tok_o
);

	logic       in_msg;       // between sop and eop
	logic       field_start;  // previous byte was SOH
	logic [1:0] tag_state;    // 0 idle, 1 saw "1", 2 saw "10"
	logic       trailer;      // checksum tag seen in this message

	logic       accept;
	logic       at_start;
	logic [1:0] tag_cur;
	logic       trailer_cur;
	logic [1:0] tag_next;
	logic       trailer_next;
	fix_stream_pkg::tok_kind_t kind_d;

	// a sop byte always opens a fresh message
	assign accept      = byte_valid_i && (sop_i || in_msg);
	assign at_start    = sop_i || field_start;
	assign tag_cur     = sop_i ? 2'd0 : tag_state;
	assign trailer_cur = sop_i ? 1'b0 : trailer;

	// -----------------------------------------------------------------------
	// classify the incoming byte
	// -----------------------------------------------------------------------
	always_comb begin
		tag_next     = 2'd0;
		trailer_next = trailer_cur;
		kind_d       = fix_stream_pkg::TOK_BODY;
		if (eop_i) begin
			kind_d = fix_stream_pkg::TOK_END;
		end else if (trailer_cur) begin
			kind_d = fix_stream_pkg::TOK_DIGIT;
		end else if (tag_cur == 2'd2 && data_i == `FIX_EQ) begin
			kind_d       = fix_stream_pkg::TOK_CHK_TAG;
			trailer_next = 1'b1;
		end else if (at_start && data_i == `FIX_CHK_TAG0) begin
			tag_next = 2'd1;
		end else if (tag_cur == 2'd1 && data_i == `FIX_CHK_TAG1) begin
			tag_next = 2'd2;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			in_msg      <= 1'b0;
			field_start <= 1'b0;
			tag_state   <= 2'd0;
			trailer     <= 1'b0;
			tok_o.valid <= 1'b0;
		end else begin
			tok_o.valid <= accept;
			if (accept) begin
				in_msg      <= !eop_i;
				field_start <= (data_i == `FIX_SOH);
				tag_state   <= tag_next;
				trailer     <= trailer_next;
			end
		end
	end

	// token payload, qualified by valid
	always_ff @(posedge clk) begin
		tok_o.kind       <= kind_d;
		tok_o.data       <= data_i;
		tok_o.in_trailer <= trailer_next;
	end

endmodule

// ==== source/checksum_accum.sv ====
// Checksum accumulator
// Second pipeline stage. Keeps the modulo-256 sum of body bytes and
// a snapshot taken at every SOH. The "=" of the trailer tag latches
// the snapshot, so the "10=" bytes never reach the computed sum.

`timescale 1ns/10ps
`include "fix_params.svh"

module checksum_accum (
	input  logic                      clk,
	input  logic                      rst,
	input  fix_stream_pkg::byte_tok_t tok_i,
	output fix_stream_pkg::sum_tok_t  tok_o
);

	logic [7:0] sum_q;   // running sum
	logic [7:0] snap_q;  // sum up to the last SOH
	logic [7:0] comp_q;  // latched message checksum
	logic [7:0] sum_d;
	logic [7:0] comp_d;

	assign sum_d  = sum_q + tok_i.data; // wraps mod 256
	assign comp_d = (tok_i.kind == fix_stream_pkg::TOK_CHK_TAG) ? snap_q : comp_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			sum_q           <= 8'h00;
			snap_q          <= 8'h00;
			comp_q          <= 8'h00;
			tok_o.tok.valid <= 1'b0;
		end else begin
			tok_o.tok.valid <= tok_i.valid;
			if (tok_i.valid) begin
				case (tok_i.kind)
					fix_stream_pkg::TOK_BODY: begin
						sum_q <= sum_d;
						if (tok_i.data == `FIX_SOH)
							snap_q <= sum_d;
					end
					fix_stream_pkg::TOK_CHK_TAG: comp_q <= comp_d;
					fix_stream_pkg::TOK_END: begin
						// next token opens a new message
						sum_q  <= 8'h00;
						snap_q <= 8'h00;
						comp_q <= 8'h00;
					end
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		tok_o.tok.kind       <= tok_i.kind;
		tok_o.tok.data       <= tok_i.data;
		tok_o.tok.in_trailer <= tok_i.in_trailer;
		tok_o.computed       <= comp_d;
	end

endmodule

// ==== source/chk_digit_decoder.sv ====
// Checksum digit decoder
// Third pipeline stage. Turns the ascii digits after "10=" into a
// binary value, counts them and flags any byte that is not a
// decimal digit or that comes after the third digit.

`timescale 1ns/10ps
`include "fix_params.svh"

module chk_digit_decoder (
	input  logic                     clk,
	input  logic                     rst,
	input  fix_stream_pkg::sum_tok_t tok_i,
	output fix_stream_pkg::dec_tok_t tok_o
);

	logic [9:0] value_q;
	logic [1:0] cnt_q;
	logic       bad_q;
	logic [9:0] value_d;
	logic [1:0] cnt_d;
	logic       bad_d;
	logic       is_digit;
	logic [7:0] digit;

	assign is_digit = (tok_i.tok.data >= `FIX_DIGIT_LO) && (tok_i.tok.data <= `FIX_DIGIT_HI);
	assign digit    = tok_i.tok.data - `FIX_DIGIT_LO;

	always_comb begin
		value_d = value_q;
		cnt_d   = cnt_q;
		bad_d   = bad_q;
		if (tok_i.tok.kind == fix_stream_pkg::TOK_CHK_TAG) begin
			value_d = 10'd0;
			cnt_d   = 2'd0;
			bad_d   = 1'b0;
		end else if (tok_i.tok.kind == fix_stream_pkg::TOK_DIGIT) begin
			if (cnt_q == `FIX_CHK_DIGITS) begin
				bad_d = 1'b1; // too many digits
			end else begin
				cnt_d = cnt_q + 2'd1;
				if (is_digit)
					value_d = value_q * 10'd10 + {2'b00, digit}; // at most 999
				else
					bad_d = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			value_q              <= 10'd0;
			cnt_q                <= 2'd0;
			bad_q                <= 1'b0;
			tok_o.stok.tok.valid <= 1'b0;
		end else begin
			tok_o.stok.tok.valid <= tok_i.tok.valid;
			if (tok_i.tok.valid) begin
				// clear at the end so a tagless message starts from zero
				if (tok_i.tok.kind == fix_stream_pkg::TOK_END) begin
					value_q <= 10'd0;
					cnt_q   <= 2'd0;
					bad_q   <= 1'b0;
				end else begin
					value_q <= value_d;
					cnt_q   <= cnt_d;
					bad_q   <= bad_d;
				end
			end
		end
	end

	// running decode goes out with every token
	always_ff @(posedge clk) begin
		tok_o.stok.tok.kind       <= tok_i.tok.kind;
		tok_o.stok.tok.data       <= tok_i.tok.data;
		tok_o.stok.tok.in_trailer <= tok_i.tok.in_trailer;
		tok_o.stok.computed       <= tok_i.computed;
		tok_o.value               <= value_d;
		tok_o.ndigits             <= cnt_d;
		tok_o.bad_digit           <= bad_d;
	end

endmodule

// ==== source/chk_verdict.sv ====
// Checksum verdict
// Last pipeline stage. At the end byte of a message it checks the
// trailer format, compares the received value with the computed
// sum and pulses one result out.

`timescale 1ns/10ps
`include "fix_params.svh"

module chk_verdict (
	input  logic                        clk,
	input  logic                        rst,
	input  fix_stream_pkg::dec_tok_t    tok_i,
	output logic                        result_valid_o,
	output fix_result_pkg::chk_result_t result_o
);

	logic                     is_end;
	logic                     fmt_err;
	logic                     sums_eq;
	fix_result_pkg::chk_sum_t received;

	assign is_end   = tok_i.stok.tok.valid && (tok_i.stok.tok.kind == fix_stream_pkg::TOK_END);
	assign received = tok_i.value[7:0];
	assign sums_eq  = (received == tok_i.stok.computed);

	// no tag, a bad byte, wrong digit count or out of byte range
	assign fmt_err = !tok_i.stok.tok.in_trailer || tok_i.bad_digit ||
		(tok_i.ndigits != `FIX_CHK_DIGITS) || (tok_i.value > 10'd255);

	always_ff @(posedge clk) begin
		if (rst) begin
			result_valid_o <= 1'b0;
			result_o       <= '0;
		end else begin
			result_valid_o <= is_end; // one-cycle pulse
			if (is_end) begin
				result_o.computed   <= tok_i.stok.computed;
				result_o.received   <= received;
				result_o.match      <= !fmt_err && sums_eq;
				result_o.format_err <= fmt_err;
			end
		end
	end

endmodule

// ==== source/fix_checksum_top.sv ====
// FIX checksum checker top level
// Four-stage pipeline: field parser, checksum accumulator, digit
// decoder and verdict. One result pulse comes out four cycles after
// the last byte of each message.

`timescale 1ns/10ps

module fix_checksum_top (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        byte_valid_i,
	input  logic                        sop_i,
	input  logic                        eop_i,
	input  logic [7:0]                  data_i,
	output logic                        result_valid_o,
	output fix_result_pkg::chk_result_t result_o
);

	fix_stream_pkg::byte_tok_t byte_tok;
	fix_stream_pkg::sum_tok_t  sum_tok;
	fix_stream_pkg::dec_tok_t  dec_tok;

	fix_field_parser parser_i (
		.clk          (clk),
		.rst          (rst),
		.byte_valid_i (byte_valid_i),
		.sop_i        (sop_i),
		.eop_i        (eop_i),
		.data_i       (data_i),
		.tok_o        (byte_tok)
	);

	checksum_accum accum_i (
		.clk   (clk),
		.rst   (rst),
		.tok_i (byte_tok),
		.tok_o (sum_tok)
	);

	chk_digit_decoder decoder_i (
		.clk   (clk),
		.rst   (rst),
		.tok_i (sum_tok),
		.tok_o (dec_tok)
	);

	chk_verdict verdict_i (
		.clk            (clk),
		.rst            (rst),
		.tok_i          (dec_tok),
		.result_valid_o (result_valid_o),
		.result_o       (result_o)
	);

endmodule

// ==== bench/tb_fix_checksum.sv ====
// Testbench for the FIX checksum checker
// Directed tests send tag=value messages through the pipeline and
// compare each verdict with a sum worked out from the sent bytes.

`timescale 1ns/10ps
`include "fix_params.svh"

module tb_fix_checksum;

	localparam int CLK_PERIOD  = 100;
	localparam int NUM_MSGS    = 16;  // upper bound over all tests
	localparam int MAX_MSG_LEN = 40;
	localparam int MAX_GAP     = 4;
	localparam int WATCHDOG_CYCLES = NUM_MSGS * (MAX_MSG_LEN + MAX_GAP + 14) + 100;

	localparam int CHK_ALL   = 0; // every result field
	localparam int CHK_SUM   = 1; // flags and computed
	localparam int CHK_FLAGS = 2; // flags only

	logic                        clk;
	logic                        rst;
	logic                        byte_valid_i;
	logic                        sop_i;
	logic                        eop_i;
	logic [7:0]                  data_i;
	logic                        result_valid_o;
	fix_result_pkg::chk_result_t result_o;

	logic [15:0]                 lfsr_q;
	int                          cyc;
	logic [7:0]                  msg_q[$];     // message under construction
	fix_result_pkg::chk_result_t exp_q[$];
	int                          exp_mode_q[$];
	int                          exp_cyc_q[$];
	fix_result_pkg::chk_result_t got_q[$];
	int                          got_cyc_q[$];

	fix_checksum_top dut_i (
		.clk            (clk),
		.rst            (rst),
		.byte_valid_i   (byte_valid_i),
		.sop_i          (sop_i),
		.eop_i          (eop_i),
		.data_i         (data_i),
		.result_valid_o (result_valid_o),
		.result_o       (result_o)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk) cyc <= cyc + 1;

	// results are captured away from the active edge
	always @(negedge clk) begin
		if (result_valid_o) begin
			got_q.push_back(result_o);
			got_cyc_q.push_back(cyc + 1); // edge that samples the pulse
		end
	end

	// ------------------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------------------
	// galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output int val);
		val = 0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q);
			val    = (val << 1) | lfsr_q[0];
		end
	endtask

	task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s, got %0d expected %0d", $time, what, got, exp);
			$display("Verification failed");
			$fatal(1, "stopping on first mismatch");
		end
	endtask

	// reference sum over every byte queued so far
	function automatic logic [7:0] model_sum();
		logic [7:0] s;
		s = 8'h00;
		foreach (msg_q[i])
			s = s + msg_q[i]; // wraps mod 256
		return s;
	endfunction

	// verdict rule: a well formed three-digit trailer up to 255 that equals the sum
	function automatic fix_result_pkg::chk_result_t expected_result(input logic [7:0] sum,
			input int value, input logic well_formed);
		fix_result_pkg::chk_result_t r;
		r.computed   = sum;
		r.received   = value[7:0];
		r.format_err = !well_formed || (value > 255);
		r.match      = !r.format_err && (value == sum);
		return r;
	endfunction

	task automatic add_text(input string s);
		for (int i = 0; i < s.len(); i++)
			msg_q.push_back(s[i]);
	endtask

	task automatic add_soh();
		msg_q.push_back(`FIX_SOH);
	endtask

	task automatic add_trailer(input int value);
		add_text($sformatf("10=%03d", value));
		add_soh();
	endtask

	task automatic add_std_body();
		add_text("8=FIX.4.2");
		add_soh();
		add_text("35=D");
		add_soh();
		add_text("55=ABC");
		add_soh();
	endtask

	task automatic add_random_body();
		int nfields;
		int len;
		int r;
		take_bits(2, nfields);
		for (int f = 0; f <= nfields; f++) begin
			take_bits(4, r);
			msg_q.push_back(8'h41 + r[7:0]); // tag letter, never "1"
			msg_q.push_back(`FIX_EQ);
			take_bits(2, len);
			for (int c = 0; c <= len; c++) begin
				take_bits(6, r);
				msg_q.push_back(8'h21 + r[7:0]); // printable, no SOH
			end
			add_soh();
		end
	endtask

	task automatic drive(input logic valid, input logic sop, input logic eop, input logic [7:0] data);
		@(posedge clk);
		#10;
		byte_valid_i = valid;
		sop_i        = sop;
		eop_i        = eop;
		data_i       = data;
	endtask

	task automatic send_msg(input fix_result_pkg::chk_result_t exp, input int mode);
		int last;
		last = msg_q.size() - 1;
		for (int i = 0; i <= last; i++)
			drive(1'b1, i == 0, i == last, msg_q[i]);
		exp_cyc_q.push_back(cyc + 1 + 4); // eop sampled on the next edge
		exp_q.push_back(exp);
		exp_mode_q.push_back(mode);
		msg_q.delete();
	endtask

	task automatic expect_results();
		fix_result_pkg::chk_result_t got;
		fix_result_pkg::chk_result_t exp;
		int                          mode;
		int                          waited;
		drive(1'b0, 1'b0, 1'b0, 8'h00);
		while (exp_q.size() > 0) begin
			waited = 0;
			while (got_q.size() == 0 && waited < 12) begin
				@(posedge clk);
				waited++;
			end
			if (got_q.size() == 0) begin
				$display("no result came out of the checker for a sent message");
				$display("Verification failed");
				$fatal(1, "missing result");
			end
			got  = got_q.pop_front();
			exp  = exp_q.pop_front();
			mode = exp_mode_q.pop_front();
			check_eq(got_cyc_q.pop_front(), exp_cyc_q.pop_front(), "result latency");
			check_eq(got.format_err, exp.format_err, "format_err");
			check_eq(got.match, exp.match, "match");
			if (mode != CHK_FLAGS)
				check_eq(got.computed, exp.computed, "computed");
			if (mode == CHK_ALL)
				check_eq(got.received, exp.received, "received");
		end
	endtask

	// ------------------------------------------------------------------------
	// tests
	// ------------------------------------------------------------------------
	task automatic test_good_msg();
		logic [7:0] s;
		add_std_body();
		s = model_sum();
		add_trailer(s);
		send_msg(expected_result(s, s, 1'b1), CHK_ALL);
		expect_results();
	endtask

	task automatic test_wrong_value();
		logic [7:0] s;
		int         v;
		add_std_body();
		s = model_sum();
		v = (s + 17) % 256;
		add_trailer(v);
		send_msg(expected_result(s, v, 1'b1), CHK_ALL);
		expect_results();
	endtask

	task automatic test_bad_trailer();
		logic [7:0] s;
		add_std_body();
		s = model_sum();
		add_text("10=1A7"); // letter among the digits
		add_soh();
		send_msg(expected_result(s, 0, 1'b0), CHK_SUM);
		add_std_body();
		add_text("10=42");  // only two digits
		add_soh();
		send_msg(expected_result(s, 42, 1'b0), CHK_SUM);
		add_std_body();
		add_trailer(300);
		send_msg(expected_result(s, 300, 1'b1), CHK_ALL);
		expect_results();
	endtask

	task automatic test_tag_position();
		logic [7:0] s;
		add_std_body(); // no checksum field at all
		send_msg(expected_result(8'h00, 0, 1'b0), CHK_FLAGS);
		add_text("8=FIX.4.2");
		add_soh();
		add_text("58=A10=B"); // tag text inside a value
		add_soh();
		s = model_sum();
		add_trailer(s);
		send_msg(expected_result(s, s, 1'b1), CHK_ALL);
		expect_results();
	endtask

	task automatic test_random_stream();
		logic [7:0] s;
		int         v;
		int         gap;
		int         r;
		drive(1'b1, 1'b0, 1'b0, 8'h31); // stray byte outside a message
		for (int m = 0; m < 8; m++) begin
			take_bits(2, gap);
			for (int g = 0; g < gap; g++) begin
				take_bits(1, r);
				if (r) begin
					take_bits(8, r);
					drive(1'b1, 1'b0, 1'b0, r[7:0]);
				end else begin
					drive(1'b0, 1'b0, 1'b0, 8'h00);
				end
			end
			add_random_body();
			s = model_sum();
			take_bits(1, r);
			v = r ? int'(s) : int'(s ^ 8'h5A);
			add_trailer(v);
			send_msg(expected_result(s, v, 1'b1), CHK_ALL);
		end
		expect_results();
	endtask

	// ------------------------------------------------------------------------
	// main sequence and watchdog
	// ------------------------------------------------------------------------
	initial begin
		lfsr_q       = 16'd63;
		rst          = 1'b1;
		byte_valid_i = 1'b0;
		sop_i        = 1'b0;
		eop_i        = 1'b0;
		data_i       = 8'h00;
		repeat (2) @(posedge clk);
		#10;
		rst = 1'b0;
		check_eq(result_valid_o, 1'b0, "result_valid_o after reset");
		check_eq(result_o, 0, "result_o after reset");
		test_good_msg();
		test_wrong_value();
		test_bad_trailer();
		test_tag_position();
		test_random_stream();
		repeat (8) @(posedge clk);
		check_eq(got_q.size(), 0, "results without a message");
		$display("Verification passed");
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Verification failed");
		$fatal(1, "watchdog expired");
	end

endmodule

// ==== tb.f ====
+incdir+source
source/fix_stream_pkg.sv
source/fix_result_pkg.sv
source/fix_field_parser.sv
source/checksum_accum.sv
source/chk_digit_decoder.sv
source/chk_verdict.sv
source/fix_checksum_top.sv
bench/tb_fix_checksum.sv
